// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_idu
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/commit_reg.sv
`timescale 1ns/1ps
`default_nettype none

module commit_reg #(
	parameter type payload_t = logic
) (
	input  wire           sys_clk,
	input  wire           rst_n,
	input  wire payload_t d,
	output payload_t      q
);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/exu_mode_gen.sv
`timescale 1ns/1ps
`default_nettype none

module exu_mode_gen (
	idu_dec_if.consumer          dec,
	output idu_pkg::exu_mode_t   exu_mode
);
	import idu_pkg::*;

	exu_mode_t alu_op;

	// operation part, source bit added below
	always_comb begin
		case (dec.funct3)
			3'b000: alu_op = (dec.op_class == op_alu_r && !dec.funct7_zero) ? exu_sub : '0;
			3'b001: alu_op = exu_sl;
			3'b010: alu_op = exu_scmp;
			3'b011: alu_op = exu_unscmp;
			3'b100: alu_op = exu_xor;
			3'b101: alu_op = dec.funct7_b5 ? exu_ssr : exu_unssr;
			3'b110: alu_op = exu_or;
			default: alu_op = exu_and;
		endcase
	end

	always_comb begin
		case (dec.op_class)
			op_alu_r:                   exu_mode = alu_op;
			op_alu_i:                   exu_mode = alu_op | exu_src_imm;
			op_load, op_store, op_jalr: exu_mode = exu_src_imm;
			// blt and bge signed, the rest unsigned
			op_branch: begin
				exu_mode = (dec.funct3[2:1] == 2'b10) ? exu_scmp : exu_unscmp;
			end
			default:                    exu_mode = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu (
	input  wire                                sys_clk,
	input  wire                                rst_n,
	input  wire  [idu_pkg::xlen-1:0]           inst,
	input  wire  [idu_pkg::xlen-1:0]           gpr_rdata1,
	input  wire  [idu_pkg::xlen-1:0]           gpr_rdata2,
	input  wire  [idu_pkg::xlen-1:0]           exu_data,
	input  wire  [idu_pkg::xlen-1:0]           mem_rdata,
	input  wire  [idu_pkg::xlen-1:0]           pc,
	input  wire  [idu_pkg::ifu_state_w-1:0]    ifu_state,
	output logic [idu_pkg::reg_addr_w-1:0]     gpr_raddr1,
	output logic [idu_pkg::reg_addr_w-1:0]     gpr_raddr2,
	output logic                               gpr_wen,
	output logic [idu_pkg::reg_addr_w-1:0]     gpr_waddr,
	output logic [idu_pkg::xlen-1:0]           gpr_wdata,
	output logic [idu_pkg::xlen-1:0]           imm,
	output logic                               pc_wen,
	output logic [idu_pkg::xlen-1:0]           pc_wdata,
	output idu_pkg::exu_mode_t                 exu_mode,
	output logic                               mem_valid,
	output logic                               mem_wen,
	output logic [idu_pkg::xlen-1:0]           mem_raddr,
	output logic [idu_pkg::xlen-1:0]           mem_waddr,
	output logic [idu_pkg::xlen-1:0]           mem_wdata,
	output logic [3:0]                         mem_wmask,
	output idu_pkg::rbyte_num_t                mem_rbyte_num
);
	import idu_pkg::*;

	gpr_wb_t  wb_d;
	gpr_wb_t  wb_q;
	pc_upd_t  upd_d;
	pc_upd_t  upd_q;
	mem_req_t req_d;
	mem_req_t req_q;

	idu_dec_if dec ();

	inst_decoder u_dec (.inst(inst), .ifu_state(ifu_state), .dec(dec.producer));
	exu_mode_gen u_mode (.dec(dec.consumer), .exu_mode(exu_mode));

	wb_ctrl u_wb (
		.dec(dec.consumer), .pc(pc), .exu_data(exu_data), .mem_rdata(mem_rdata),
		.gpr_raddr1(gpr_raddr1), .gpr_raddr2(gpr_raddr2), .wb(wb_d)
	);

	pc_ctrl u_pc (
		.dec(dec.consumer), .pc(pc), .exu_data(exu_data), .gpr_rdata1(gpr_rdata1), .upd(upd_d)
	);

	mem_req_gen u_mem (
		.dec(dec.consumer), .exu_data(exu_data), .gpr_rdata2(gpr_rdata2), .req(req_d)
	);

	// commit stage, one register per payload
	commit_reg #(.payload_t(gpr_wb_t)) u_wb_reg (
		.sys_clk(sys_clk), .rst_n(rst_n), .d(wb_d), .q(wb_q)
	);
	commit_reg #(.payload_t(pc_upd_t)) u_pc_reg (
		.sys_clk(sys_clk), .rst_n(rst_n), .d(upd_d), .q(upd_q)
	);
	commit_reg #(.payload_t(mem_req_t)) u_mem_reg (
		.sys_clk(sys_clk), .rst_n(rst_n), .d(req_d), .q(req_q)
	);

	assign imm           = dec.imm;
	assign gpr_wen       = wb_q.wen;
	assign gpr_waddr     = wb_q.waddr;
	assign gpr_wdata     = wb_q.wdata;
	assign pc_wen        = upd_q.wen;
	assign pc_wdata      = upd_q.wdata;
	assign mem_valid     = req_q.valid;
	assign mem_wen       = req_q.wen;
	assign mem_raddr     = req_q.raddr;
	assign mem_waddr     = req_q.waddr;
	assign mem_wdata     = req_q.wdata;
	assign mem_wmask     = req_q.wmask;
	assign mem_rbyte_num = req_q.rbyte_num;

endmodule

`default_nettype wire

// File: hdl/idu_dec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface idu_dec_if;
	import idu_pkg::*;

	op_class_e             op_class;
	logic [2:0]            funct3;
	logic                  funct7_b5;
	logic                  funct7_zero;
	logic [reg_addr_w-1:0] rd;
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [xlen-1:0]       imm;

	modport producer (output op_class, funct3, funct7_b5, funct7_zero, rd, rs1, rs2, imm);
	modport consumer (input op_class, funct3, funct7_b5, funct7_zero, rd, rs1, rs2, imm);

endinterface

`default_nettype wire

// File: hdl/idu_pkg.sv
`default_nettype none

package idu_pkg;

	localparam int xlen        = 32;
	localparam int reg_addr_w  = 5;
	localparam int ifu_state_w = 2;

	// fetch unit holds no instruction
	localparam logic [ifu_state_w-1:0] ifu_idle = 2'b01;

	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;

	// alu mode word, all zeros is add of two registers
	typedef logic [12:0] exu_mode_t;

	localparam exu_mode_t exu_src_imm = 13'h0001;
	localparam exu_mode_t exu_sub     = 13'h0002;
	localparam exu_mode_t exu_unscmp  = 13'h0004;
	localparam exu_mode_t exu_scmp    = 13'h0008;
	localparam exu_mode_t exu_unssr   = 13'h0010;
	localparam exu_mode_t exu_ssr     = 13'h0020;
	localparam exu_mode_t exu_sl      = 13'h0040;
	localparam exu_mode_t exu_xor     = 13'h0080;
	localparam exu_mode_t exu_and     = 13'h0100;
	localparam exu_mode_t exu_or      = 13'h0200;
	localparam exu_mode_t exu_not     = 13'h0400;

	// compare result from the alu, zero means equal
	localparam logic [xlen-1:0] exu_lt_result = 32'd4;

	typedef enum logic [3:0] {
		op_none, op_alu_r, op_alu_i, op_lui, op_auipc,
		op_jal, op_jalr, op_branch, op_load, op_store
	} op_class_e;

	typedef enum logic [2:0] {
		imm_none, imm_i, imm_u, imm_s, imm_b, imm_j, imm_shamt
	} imm_type_e;

	// 00 one byte, 01 two, 10 four
	typedef logic [1:0] rbyte_num_t;

	typedef struct packed {
		logic                  wen;
		logic [reg_addr_w-1:0] waddr;
		logic [xlen-1:0]       wdata;
	} gpr_wb_t;

	typedef struct packed {
		logic            wen;
		logic [xlen-1:0] wdata;
	} pc_upd_t;

	typedef struct packed {
		logic            valid;
		logic            wen;
		logic [xlen-1:0] raddr;
		logic [xlen-1:0] waddr;
		logic [xlen-1:0] wdata;
		logic [3:0]      wmask;
		rbyte_num_t      rbyte_num;
	} mem_req_t;

endpackage

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  wire [idu_pkg::xlen-1:0]        inst,
	input  wire [idu_pkg::ifu_state_w-1:0] ifu_state,
	idu_dec_if.producer                    dec
);
	import idu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	op_class_e  cls_raw;
	op_class_e  cls;
	imm_type_e  imm_type;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		cls_raw = op_none;
		case (opcode)
			opc_op: begin
				if (funct7 == 7'b0000000 ||
				    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
					cls_raw = op_alu_r;
				end
			end
			opc_op_imm: begin
				// srai keeps bit 25 as shamt[5]
				if ((funct3 != 3'b001 && funct3 != 3'b101) ||
				    (funct7 == 7'b0000000) ||
				    (funct3 == 3'b101 && funct7[6:1] == 6'b010000)) begin
					cls_raw = op_alu_i;
				end
			end
			opc_load: begin
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
					cls_raw = op_load;
				end
			end
			opc_store: begin
				if (!funct3[2] && funct3 != 3'b011) begin
					cls_raw = op_store;
				end
			end
			opc_branch: begin
				if (funct3[2:1] != 2'b01) begin
					cls_raw = op_branch;
				end
			end
			opc_jalr: begin
				if (funct3 == 3'b000) begin
					cls_raw = op_jalr;
				end
			end
			opc_lui:   cls_raw = op_lui;
			opc_auipc: cls_raw = op_auipc;
			opc_jal:   cls_raw = op_jal;
			default:   cls_raw = op_none;
		endcase
	end

	assign cls = (ifu_state == ifu_idle) ? op_none : cls_raw;

	always_comb begin
		case (cls)
			op_alu_i:          imm_type = (funct3 == 3'b101) ? imm_shamt : imm_i;
			op_load, op_jalr:  imm_type = imm_i;
			op_lui, op_auipc:  imm_type = imm_u;
			op_store:          imm_type = imm_s;
			op_branch:         imm_type = imm_b;
			op_jal:            imm_type = imm_j;
			default:           imm_type = imm_none;
		endcase
	end

	always_comb begin
		case (imm_type)
			imm_i:     dec.imm = {{20{inst[31]}}, inst[31:20]};
			imm_u:     dec.imm = {inst[31:12], 12'b0};
			imm_s:     dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b:     dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j:     dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			imm_shamt: dec.imm = {26'b0, inst[25:20]};
			default:   dec.imm = '0;
		endcase
	end

	assign dec.op_class    = cls;
	assign dec.funct3      = funct3;
	assign dec.funct7_b5   = funct7[5];
	assign dec.funct7_zero = (funct7 == 7'b0000000);
	assign dec.rd          = inst[11:7];
	assign dec.rs1         = inst[19:15];
	assign dec.rs2         = inst[24:20];

endmodule

`default_nettype wire

// File: hdl/mem_req_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mem_req_gen (
	idu_dec_if.consumer             dec,
	input  wire [idu_pkg::xlen-1:0] exu_data,
	input  wire [idu_pkg::xlen-1:0] gpr_rdata2,
	output idu_pkg::mem_req_t       req
);
	import idu_pkg::*;

	logic [xlen-1:0]   lane0_data;
	logic [3:0]        lane0_mask;
	logic [1:0]        rot;
	logic [2*xlen-1:0] data_dbl;
	logic [7:0]        mask_dbl;

	always_comb begin
		case (dec.funct3)
			3'b000: begin
				lane0_data = {24'b0, gpr_rdata2[7:0]};
				lane0_mask = 4'b0001;
			end
			3'b001: begin
				lane0_data = {16'b0, gpr_rdata2[15:0]};
				lane0_mask = 4'b0011;
			end
			default: begin
				lane0_data = gpr_rdata2;
				lane0_mask = 4'b1111;
			end
		endcase
	end

	// sb and sh rotate left one lane per byte, so sh at offset 3 wraps to lane 0
	assign rot      = (dec.funct3 == 3'b010) ? 2'b00 : exu_data[1:0];
	assign data_dbl = {lane0_data, lane0_data} << {rot, 3'b000};
	assign mask_dbl = {lane0_mask, lane0_mask} << rot;

	always_comb begin
		req = '0;
		if (dec.op_class == op_load) begin
			req.valid     = 1'b1;
			req.raddr     = exu_data;
			req.rbyte_num = rbyte_num_t'(dec.funct3[1:0]);
		end else if (dec.op_class == op_store) begin
			req.wen   = 1'b1;
			req.waddr = exu_data;
			req.wdata = data_dbl[2*xlen-1:xlen];
			req.wmask = mask_dbl[7:4];
		end
	end

endmodule

`default_nettype wire

// File: hdl/pc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl (
	idu_dec_if.consumer             dec,
	input  wire [idu_pkg::xlen-1:0] pc,
	input  wire [idu_pkg::xlen-1:0] exu_data,
	input  wire [idu_pkg::xlen-1:0] gpr_rdata1,
	output idu_pkg::pc_upd_t        upd
);
	import idu_pkg::*;

	logic            taken;
	logic [xlen-1:0] pc_rel;
	logic [xlen-1:0] reg_rel;

	assign pc_rel  = pc + dec.imm;
	assign reg_rel = gpr_rdata1 + dec.imm;

	always_comb begin
		case (dec.funct3)
			3'b000:         taken = (exu_data == '0);
			3'b001:         taken = (exu_data != '0);
			3'b100, 3'b110: taken = (exu_data == exu_lt_result);
			default:        taken = (exu_data != exu_lt_result);
		endcase
	end

	always_comb begin
		upd = '0;
		case (dec.op_class)
			op_jal: begin
				upd.wen   = 1'b1;
				upd.wdata = pc_rel;
			end
			op_jalr: begin
				upd.wen   = 1'b1;
				upd.wdata = {reg_rel[xlen-1:1], 1'b0};
			end
			op_branch: begin
				upd.wen   = taken;
				upd.wdata = taken ? pc_rel : '0;
			end
			default: upd = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/wb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ctrl (
	idu_dec_if.consumer                     dec,
	input  wire [idu_pkg::xlen-1:0]         pc,
	input  wire [idu_pkg::xlen-1:0]         exu_data,
	input  wire [idu_pkg::xlen-1:0]         mem_rdata,
	output logic [idu_pkg::reg_addr_w-1:0]  gpr_raddr1,
	output logic [idu_pkg::reg_addr_w-1:0]  gpr_raddr2,
	output idu_pkg::gpr_wb_t                wb
);
	import idu_pkg::*;

	logic [xlen-1:0] alu_val;
	logic [xlen-1:0] load_val;
	logic            slt_op;

	assign gpr_raddr1 = (dec.op_class inside {op_alu_r, op_alu_i, op_jalr, op_branch,
		op_load, op_store}) ? dec.rs1 : '0;
	assign gpr_raddr2 = (dec.op_class inside {op_alu_r, op_branch, op_store}) ? dec.rs2 : '0;

	// slt family writes a flag
	assign slt_op  = (dec.funct3[2:1] == 2'b01);
	assign alu_val = slt_op ? {{(xlen-1){1'b0}}, exu_data == exu_lt_result} : exu_data;

	always_comb begin
		case (dec.funct3)
			3'b000:  load_val = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			3'b001:  load_val = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			3'b100:  load_val = {24'b0, mem_rdata[7:0]};
			3'b101:  load_val = {16'b0, mem_rdata[15:0]};
			default: load_val = mem_rdata;
		endcase
	end

	always_comb begin
		wb = '0;
		case (dec.op_class)
			op_alu_r, op_alu_i: wb.wdata = alu_val;
			op_lui:             wb.wdata = dec.imm;
			op_auipc:           wb.wdata = pc + dec.imm;
			op_jal, op_jalr:    wb.wdata = pc + xlen'(4);
			op_load:            wb.wdata = load_val;
			default:            wb.wdata = '0;
		endcase
		wb.wen = dec.op_class inside {op_alu_r, op_alu_i, op_lui, op_auipc, op_jal, op_jalr,
			op_load};
		if (wb.wen) begin
			wb.waddr = dec.rd;
		end
	end

endmodule

`default_nettype wire

// File: sim/idu_props.sv
`timescale 1ns/1ps
`default_nettype none

module idu_props (
	input wire                     sys_clk,
	input wire                     rst_n,
	input wire                     gpr_wen,
	input wire                     pc_wen,
	input wire [idu_pkg::xlen-1:0] pc_wdata,
	input wire                     mem_valid,
	input wire                     mem_wen,
	input wire [3:0]               mem_wmask
);

	// a request is a load or a store, never both
	a_one_mem_op: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(mem_valid && mem_wen))
		else $error("load and store requested in the same cycle");

	a_mask_with_wen: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(mem_wmask != 4'b0000) == mem_wen)
		else $error("store mask does not match store enable");

	a_target_aligned: assert property (@(posedge sys_clk) disable iff (!rst_n)
		pc_wen |-> !pc_wdata[0])
		else $error("redirect target has bit 0 set");

	a_reset_quiet: assert property (@(posedge sys_clk)
		!rst_n |-> !(gpr_wen || pc_wen || mem_valid || mem_wen))
		else $error("commit enable high during reset");

endmodule

bind idu idu_props u_props (
	.sys_clk(sys_clk), .rst_n(rst_n), .gpr_wen(gpr_wen), .pc_wen(pc_wen),
	.pc_wdata(pc_wdata), .mem_valid(mem_valid), .mem_wen(mem_wen), .mem_wmask(mem_wmask)
);

`default_nettype wire

// File: sim/tb_idu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_idu;
	import idu_pkg::*;

	localparam int clk_period   = 4;
	localparam int reset_cycles = 10;
	localparam int num_instr    = 2000;
	localparam int watchdog_ns  = 2 * (reset_cycles + num_instr + 4) * clk_period;

	logic                   sys_clk;
	logic                   rst_n;
	logic [xlen-1:0]        inst;
	logic [xlen-1:0]        gpr_rdata1;
	logic [xlen-1:0]        gpr_rdata2;
	logic [xlen-1:0]        exu_data;
	logic [xlen-1:0]        mem_rdata;
	logic [xlen-1:0]        pc;
	logic [ifu_state_w-1:0] ifu_state;

	logic [reg_addr_w-1:0]  gpr_raddr1;
	logic [reg_addr_w-1:0]  gpr_raddr2;
	logic [reg_addr_w-1:0]  gpr_waddr;
	logic                   gpr_wen;
	logic                   pc_wen;
	logic                   mem_valid;
	logic                   mem_wen;
	logic [xlen-1:0]        gpr_wdata;
	logic [xlen-1:0]        imm;
	logic [xlen-1:0]        pc_wdata;
	logic [xlen-1:0]        mem_raddr;
	logic [xlen-1:0]        mem_waddr;
	logic [xlen-1:0]        mem_wdata;
	exu_mode_t              exu_mode;
	logic [3:0]             mem_wmask;
	rbyte_num_t             mem_rbyte_num;

	// current instruction as generated
	int              kind;
	logic            idle;
	logic            alt;
	logic [2:0]      f3;
	logic [4:0]      rd;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [31:0]     imm_v;

	logic [4:0]      exp_raddr1;
	logic [4:0]      exp_raddr2;
	logic [31:0]     exp_imm;
	exu_mode_t       exp_mode;
	gpr_wb_t         nx_wb;
	gpr_wb_t         pv_wb;
	pc_upd_t         nx_pc;
	pc_upd_t         pv_pc;
	mem_req_t        nx_mem;
	mem_req_t        pv_mem;

	int              errors;
	int              cyc;
	logic [31:0]     seed_ret;

	idu uut (.*);

	initial sys_clk = 1'b0;
	always #(clk_period / 2) sys_clk = ~sys_clk;

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic exu_mode_t alu_mode(input logic [2:0] fn3, input logic alt_op,
		input logic use_imm);
		exu_mode_t m;

		case (fn3)
			3'd0:    m = (alt_op && !use_imm) ? exu_sub : '0;
			3'd1:    m = exu_sl;
			3'd2:    m = exu_scmp;
			3'd3:    m = exu_unscmp;
			3'd4:    m = exu_xor;
			3'd5:    m = alt_op ? exu_ssr : exu_unssr;
			3'd6:    m = exu_or;
			default: m = exu_and;
		endcase
		return use_imm ? (m | exu_src_imm) : m;
	endfunction

	// pick a kind, fill its fields, encode it and drive the inputs
	task automatic drive_next();
		logic [31:0] w;
		logic [11:0] i12;
		logic [12:0] b13;
		logic [20:0] j21;
		logic [19:0] u20;
		logic [5:0]  sh;
		int          pick;

		kind  = int'($urandom % 9);
		idle  = ($urandom % 8) == 0;
		rd    = 5'($urandom);
		rs1   = 5'($urandom);
		rs2   = 5'($urandom);
		i12   = 12'($urandom);
		b13   = 13'($urandom) & 13'h1ffe;
		j21   = 21'($urandom) & 21'h1ffffe;
		u20   = 20'($urandom);
		sh    = 6'($urandom);
		alt   = 1'b0;
		f3    = 3'd0;
		imm_v = {{20{i12[11]}}, i12};
		case (kind)
			0: begin
				f3    = 3'($urandom);
				alt   = (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom) : 1'b0;
				imm_v = '0;
				w     = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opc_op};
			end
			1: begin
				f3  = 3'($urandom);
				alt = (f3 == 3'd5) ? 1'($urandom) : 1'b0;
				if (f3 == 3'd1 || f3 == 3'd5) begin
					// shifts carry shamt, srai sets bit 30 and may use bit 25
					i12   = {1'b0, alt, 5'b0, sh[4:0]};
					imm_v = {27'b0, sh[4:0]};
					if (alt) begin
						i12[5] = sh[5];
						imm_v  = {26'b0, sh};
					end
				end
				w = {i12, rs1, f3, rd, opc_op_imm};
			end
			2, 3: begin
				imm_v = {u20, 12'b0};
				w     = {u20, rd, (kind == 2) ? opc_lui : opc_auipc};
			end
			4: begin
				imm_v = {{11{j21[20]}}, j21};
				w     = {j21[20], j21[10:1], j21[11], j21[19:12], rd, opc_jal};
			end
			5: w = {i12, rs1, 3'b000, rd, opc_jalr};
			6: begin
				pick  = int'($urandom % 6);
				f3    = (pick < 2) ? 3'(pick) : 3'(pick + 2);
				imm_v = {{19{b13[12]}}, b13};
				w     = {b13[12], b13[10:5], rs2, rs1, f3, b13[4:1], b13[11], opc_branch};
			end
			7: begin
				pick = int'($urandom % 5);
				f3   = (pick < 3) ? 3'(pick) : 3'(pick + 1);
				w    = {i12, rs1, f3, rd, opc_load};
			end
			default: begin
				f3 = 3'($urandom % 3);
				w  = {i12[11:5], rs2, rs1, f3, i12[4:0], opc_store};
			end
		endcase
		inst       <= w;
		gpr_rdata1 <= $urandom;
		gpr_rdata2 <= $urandom;
		mem_rdata  <= $urandom;
		pc         <= $urandom & 32'hffff_fffc;
		pick = int'($urandom % 3);
		ifu_state  <= idle ? ifu_idle : ((pick == 0) ? 2'b00 : 2'(pick + 1));
		// bias toward equal and less-than compare results
		pick = int'($urandom % 4);
		case (pick)
			0:       exu_data <= '0;
			1:       exu_data <= exu_lt_result;
			2:       exu_data <= 32'd1;
			default: exu_data <= $urandom;
		endcase
	endtask

	task automatic compute_expected();
		logic        taken;
		logic [1:0]  off;
		logic [31:0] lt_flag;
		int          nbytes;
		int          lane;
		int          k;

		exp_raddr1 = '0;
		exp_raddr2 = '0;
		exp_imm    = '0;
		exp_mode   = '0;
		nx_wb      = '0;
		nx_pc      = '0;
		nx_mem     = '0;
		if (!idle) begin
			exp_imm = imm_v;
			lt_flag = (exu_data == exu_lt_result) ? 32'd1 : 32'd0;
			if (kind != 2 && kind != 3 && kind != 4) begin
				exp_raddr1 = rs1;
			end
			if (kind == 0 || kind == 6 || kind == 8) begin
				exp_raddr2 = rs2;
			end
			case (kind)
				0, 1: begin
					exp_mode    = alu_mode(f3, alt, kind == 1);
					nx_wb.wdata = (f3 == 3'd2 || f3 == 3'd3) ? lt_flag : exu_data;
				end
				2: nx_wb.wdata = imm_v;
				3: nx_wb.wdata = pc + imm_v;
				4, 5: begin
					nx_wb.wdata = pc + 32'd4;
					nx_pc.wen   = 1'b1;
					nx_pc.wdata = pc + imm_v;
					if (kind == 5) begin
						exp_mode    = exu_src_imm;
						nx_pc.wdata = (gpr_rdata1 + imm_v) & 32'hffff_fffe;
					end
				end
				6: begin
					exp_mode = (f3 == 3'd4 || f3 == 3'd5) ? exu_scmp : exu_unscmp;
					case (f3)
						3'd0:       taken = (exu_data == 32'd0);
						3'd1:       taken = (exu_data != 32'd0);
						3'd4, 3'd6: taken = (exu_data == exu_lt_result);
						default:    taken = (exu_data != exu_lt_result);
					endcase
					if (taken) begin
						nx_pc.wen   = 1'b1;
						nx_pc.wdata = pc + imm_v;
					end
				end
				7: begin
					exp_mode     = exu_src_imm;
					nx_mem.valid = 1'b1;
					nx_mem.raddr = exu_data;
					case (f3)
						3'd0: begin
							nx_wb.wdata = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
							nx_mem.rbyte_num = 2'b00;
						end
						3'd4: begin
							nx_wb.wdata = {24'b0, mem_rdata[7:0]};
							nx_mem.rbyte_num = 2'b00;
						end
						3'd1: begin
							nx_wb.wdata = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
							nx_mem.rbyte_num = 2'b01;
						end
						3'd5: begin
							nx_wb.wdata = {16'b0, mem_rdata[15:0]};
							nx_mem.rbyte_num = 2'b01;
						end
						default: begin
							nx_wb.wdata = mem_rdata;
							nx_mem.rbyte_num = 2'b10;
						end
					endcase
				end
				default: begin
					exp_mode     = exu_src_imm;
					nx_mem.wen   = 1'b1;
					nx_mem.waddr = exu_data;
					nbytes = (f3 == 3'd0) ? 1 : ((f3 == 3'd1) ? 2 : 4);
					off    = (nbytes == 4) ? 2'b00 : exu_data[1:0];
					for (k = 0; k < nbytes; k++) begin
						lane = (int'(off) + k) % 4;
						nx_mem.wmask[lane]        = 1'b1;
						nx_mem.wdata[lane*8 +: 8] = gpr_rdata2[k*8 +: 8];
					end
				end
			endcase
			nx_wb.wen = (kind != 6 && kind != 8);
			if (nx_wb.wen) begin
				nx_wb.waddr = rd;
			end
		end
	endtask

	task automatic check_read_side();
		check_eq("gpr_raddr1", 32'(gpr_raddr1), 32'(exp_raddr1));
		check_eq("gpr_raddr2", 32'(gpr_raddr2), 32'(exp_raddr2));
		check_eq("imm", imm, exp_imm);
		check_eq("exu_mode", 32'(exu_mode), 32'(exp_mode));
	endtask

	task automatic check_commit();
		check_eq("gpr_wen", 32'(gpr_wen), 32'(pv_wb.wen));
		check_eq("gpr_waddr", 32'(gpr_waddr), 32'(pv_wb.waddr));
		check_eq("gpr_wdata", gpr_wdata, pv_wb.wdata);
		check_eq("pc_wen", 32'(pc_wen), 32'(pv_pc.wen));
		check_eq("pc_wdata", pc_wdata, pv_pc.wdata);
		check_eq("mem_valid", 32'(mem_valid), 32'(pv_mem.valid));
		check_eq("mem_wen", 32'(mem_wen), 32'(pv_mem.wen));
		check_eq("mem_raddr", mem_raddr, pv_mem.raddr);
		check_eq("mem_waddr", mem_waddr, pv_mem.waddr);
		check_eq("mem_wdata", mem_wdata, pv_mem.wdata);
		check_eq("mem_wmask", 32'(mem_wmask), 32'(pv_mem.wmask));
		check_eq("mem_rbyte_num", 32'(mem_rbyte_num), 32'(pv_mem.rbyte_num));
	endtask

	initial begin
		seed_ret   = $urandom(32'hc4748266);
		errors     = 0;
		rst_n      = 1'b0;
		inst       = '0;
		gpr_rdata1 = '0;
		gpr_rdata2 = '0;
		exu_data   = '0;
		mem_rdata  = '0;
		pc         = '0;
		ifu_state  = ifu_idle;
		kind       = 0;
		idle       = 1'b1;
		alt        = 1'b0;
		f3         = '0;
		rd         = '0;
		rs1        = '0;
		rs2        = '0;
		imm_v      = '0;
		pv_wb      = '0;
		pv_pc      = '0;
		pv_mem     = '0;
		for (cyc = 0; cyc < reset_cycles; cyc++) begin
			@(negedge sys_clk);
			check_commit();
		end
		@(posedge sys_clk);
		rst_n <= 1'b1;
		// commit shows the previous cycle, read side the current one
		for (cyc = 0; cyc < num_instr; cyc++) begin
			@(posedge sys_clk);
			drive_next();
			@(negedge sys_clk);
			compute_expected();
			check_read_side();
			check_commit();
			pv_wb  = nx_wb;
			pv_pc  = nx_pc;
			pv_mem = nx_mem;
		end
		@(negedge sys_clk);
		check_commit();
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before the test finished");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/idu_pkg.sv
hdl/idu_dec_if.sv
hdl/inst_decoder.sv
hdl/exu_mode_gen.sv
hdl/wb_ctrl.sv
hdl/pc_ctrl.sv
hdl/mem_req_gen.sv
hdl/commit_reg.sv
hdl/idu.sv
sim/idu_props.sv
sim/tb_idu.sv
